/* cpuCtrlPkg.sv */
// Shared encodings for the control front end; only six opcodes are classified, all others run as 2-cycle implied
`default_nettype none

package cpuCtrlPkg;

    // Timing states, T1 is always the opcode fetch
    typedef enum logic [2:0] {
        T1 = 3'd0,
        T2 = 3'd1,
        T3 = 3'd2,
        T4 = 3'd3,
        T5 = 3'd4,
        T6 = 3'd5,
        T7 = 3'd6
    } tState;

    typedef enum logic [2:0] {
        classImplied   = 3'd0, // Also every unlisted opcode
        classImmediate = 3'd1,
        classZeroRead  = 3'd2,
        classZeroWrite = 3'd3,
        classAbsRead   = 3'd4,
        classBreak     = 3'd5  // BRK and every taken interrupt
    } opClass;

    typedef enum logic [1:0] {
        srcNone  = 2'd0,
        srcIrq   = 2'd1,
        srcNmi   = 2'd2,
        srcReset = 2'd3
    } intSource;

    typedef enum logic [1:0] {
        addrPc      = 2'd0,
        addrOperand = 2'd1,
        addrStack   = 2'd2,
        addrVector  = 2'd3
    } addrSrc;

    localparam logic [7:0] opBrk    = 8'h00;
    localparam logic [7:0] opNop    = 8'hEA;
    localparam logic [7:0] opLdaImm = 8'hA9;
    localparam logic [7:0] opLdaZp  = 8'hA5;
    localparam logic [7:0] opStaZp  = 8'h85;
    localparam logic [7:0] opLdaAbs = 8'hAD;

    function automatic opClass classOf(input logic [7:0] opByte);
        opClass cls;
        case (opByte)
            opBrk:    cls = classBreak;
            opLdaImm: cls = classImmediate;
            opLdaZp:  cls = classZeroRead;
            opStaZp:  cls = classZeroWrite;
            opLdaAbs: cls = classAbsRead;
            default:  cls = classImplied; // NOP lands here as well
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire

/* opcodeIf.sv */
// Opcode bus between predecode, instruction register and sequencer; carries no clock of its own
`default_nettype none
`timescale 1ns/1ps

interface opcodeIf;

    logic [7:0] preOp;      // Predecoded byte, BRK when an interrupt was taken
    logic       fetchDone;  // One cycle after an advancing fetch
    logic       opLoad;     // Strobe at the end of an advancing T2
    logic [7:0] opcode;
    logic [7:0] prevOpcode;

    modport predec (
        output preOp,
        output fetchDone
    );

    modport ir (
        input  preOp,
        input  opLoad,
        output opcode,
        output prevOpcode
    );

    modport seq (
        input  preOp,
        input  fetchDone,
        output opLoad
    );

endinterface

`default_nettype wire

/* interruptUnit.sv */
// Interrupt pins are asynchronous and active low; iFlag is taken as already synchronous to phi1
`default_nettype none
`timescale 1ns/1ps

module interruptUnit #(
    parameter int syncStages = 2 // Synchronizer depth, 1 or 2
) (
    input  wire                        phi1,
    input  wire                        phi2,
    input  wire                        nmiL,
    input  wire                        irqL,
    input  wire                        resL,
    input  wire                        iFlag,
    input  wire                        intAck,
    output logic                       intReq,
    output cpuCtrlPkg::intSource       intSrc
);

    logic [syncStages-1:0][2:0] pinSync; // {resL, nmiL, irqL} per stage
    logic [2:0]                 pinNow;
    logic [1:0]                 pinPrev; // {resL, nmiL} one cycle back
    logic                       resFall;
    logic                       nmiFall;
    logic                       irqActive;
    logic                       resPend;
    logic                       nmiPend;
    logic                       served;
    cpuCtrlPkg::intSource       pick;

    assign pinNow    = pinSync[syncStages-1];
    assign resFall   = pinPrev[1] && !pinNow[2];
    assign nmiFall   = pinPrev[0] && !pinNow[1];
    assign irqActive = !pinNow[0] && !iFlag; // Level, masked by I
    assign served    = intReq && intAck;

    // Reset beats NMI beats IRQ, an edge ranks in the cycle it is seen
    always_comb begin
        if (resPend || resFall) begin
            pick = cpuCtrlPkg::srcReset;
        end else if (nmiPend || nmiFall) begin
            pick = cpuCtrlPkg::srcNmi;
        end else if (irqActive) begin
            pick = cpuCtrlPkg::srcIrq;
        end else begin
            pick = cpuCtrlPkg::srcNone;
        end
    end

    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            pinSync <= '1; // Pins idle high
            pinPrev <= 2'b11;
            resPend <= 1'b0;
            nmiPend <= 1'b0;
        end else begin
            pinSync[0] <= {resL, nmiL, irqL};
            for (int i = 1; i < syncStages; i++) begin
                pinSync[i] <= pinSync[i-1];
            end
            pinPrev <= {pinNow[2], pinNow[1]};
            // A fresh edge survives the clear of the one being served
            resPend <= (resPend && !(served && intSrc == cpuCtrlPkg::srcReset)) || resFall;
            nmiPend <= (nmiPend && !(served && intSrc == cpuCtrlPkg::srcNmi)) || nmiFall;
        end
    end

    // Request half of the four-phase link
    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            intReq <= 1'b0;
            intSrc <= cpuCtrlPkg::srcNone;
        end else if (served) begin
            intReq <= 1'b0;
        end else if (!intReq && !intAck && pick != cpuCtrlPkg::srcNone) begin
            intReq <= 1'b1;
            intSrc <= pick; // Frozen until the acknowledge
        end
    end

endmodule

`default_nettype wire

/* predecode.sv */
// Captures dataIn only on an advancing fetch edge; a pending request replaces the byte with BRK
`default_nettype none
`timescale 1ns/1ps

module predecode (
    input  wire        phi1,
    input  wire        phi2,
    input  wire  [7:0] dataIn,
    input  wire        fetch,
    input  wire        intReq,
    input  wire        intAck,
    opcodeIf.predec    op
);

    logic takeInt;

    // Same condition the sequencer uses to latch the source
    assign takeInt = intReq && !intAck;

    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            op.preOp     <= cpuCtrlPkg::opBrk;
            op.fetchDone <= 1'b0;
        end else begin
            op.fetchDone <= fetch; // Single cycle pulse in the first T2
            if (fetch) begin
                if (takeInt) begin
                    op.preOp <= cpuCtrlPkg::opBrk; // Interrupts reuse BRK
                end else begin
                    op.preOp <= dataIn;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* instructionRegister.sv */
// Opcode pair register; both entries read as BRK after reset until two instructions have loaded
`default_nettype none
`timescale 1ns/1ps

module instructionRegister (
    input  wire     phi1,
    input  wire     phi2,
    opcodeIf.ir     op
);

    logic [7:0] curOp;
    logic [7:0] oldOp;

    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            curOp <= cpuCtrlPkg::opBrk;
            oldOp <= cpuCtrlPkg::opBrk;
        end else if (op.opLoad) begin
            curOp <= op.preOp;
            oldOp <= curOp; // Previous opcode shifts along
        end
    end

    assign op.opcode     = curOp;
    assign op.prevOpcode = oldOp;

endmodule

`default_nettype wire

/* sequencer.sv */
// Timing-state sequencer; rdy stalls read cycles only, and only six opcodes get their own length
`default_nettype none
`timescale 1ns/1ps

module sequencer (
    input  wire                        phi1,
    input  wire                        phi2,
    input  wire                        rdy,
    input  wire                        intReq,
    input  wire cpuCtrlPkg::intSource  intSrc,
    output logic                       intAck,
    output logic                       sync,
    output logic                       rw,
    output cpuCtrlPkg::addrSrc         addr,
    output cpuCtrlPkg::intSource       vecSel,
    output cpuCtrlPkg::tState          state,
    output logic                       fetch,
    opcodeIf.seq                       op
);

    cpuCtrlPkg::opClass   classReg; // Class of the instruction in progress
    cpuCtrlPkg::opClass   classNow;
    cpuCtrlPkg::intSource vecReg;   // Source behind a substituted BRK
    cpuCtrlPkg::tState    nextState;
    logic                 advance;
    logic                 pushWrite;

    // In T2 the class comes straight from the predecoded byte
    assign classNow  = (state == cpuCtrlPkg::T2) ? cpuCtrlPkg::classOf(op.preOp) : classReg;
    assign sync      = (state == cpuCtrlPkg::T1);
    assign advance   = rdy || !rw; // Writes ignore rdy
    assign fetch     = sync && rdy;
    assign op.opLoad = (state == cpuCtrlPkg::T2) && advance;
    assign vecSel    = sync ? cpuCtrlPkg::srcNone : vecReg;
    assign pushWrite = (vecReg != cpuCtrlPkg::srcReset); // Reset entry only reads

    always_comb begin
        rw        = 1'b1;
        addr      = cpuCtrlPkg::addrPc;
        nextState = cpuCtrlPkg::T1;
        case (state)
            cpuCtrlPkg::T1: nextState = cpuCtrlPkg::T2;
            cpuCtrlPkg::T2: begin
                if (classNow != cpuCtrlPkg::classImplied &&
                    classNow != cpuCtrlPkg::classImmediate) begin
                    nextState = cpuCtrlPkg::T3;
                end
            end
            cpuCtrlPkg::T3: begin
                case (classNow)
                    cpuCtrlPkg::classZeroRead: addr = cpuCtrlPkg::addrOperand;
                    cpuCtrlPkg::classZeroWrite: begin
                        addr = cpuCtrlPkg::addrOperand;
                        rw   = 1'b0;
                    end
                    cpuCtrlPkg::classAbsRead: nextState = cpuCtrlPkg::T4; // High operand byte
                    cpuCtrlPkg::classBreak: begin
                        addr      = cpuCtrlPkg::addrStack;
                        rw        = !pushWrite;
                        nextState = cpuCtrlPkg::T4;
                    end
                    default: nextState = cpuCtrlPkg::T1;
                endcase
            end
            cpuCtrlPkg::T4: begin
                if (classNow == cpuCtrlPkg::classBreak) begin
                    addr      = cpuCtrlPkg::addrStack;
                    rw        = !pushWrite;
                    nextState = cpuCtrlPkg::T5;
                end else begin
                    addr = cpuCtrlPkg::addrOperand; // Absolute read
                end
            end
            cpuCtrlPkg::T5: begin
                addr      = cpuCtrlPkg::addrStack;
                rw        = !pushWrite;
                nextState = cpuCtrlPkg::T6;
            end
            cpuCtrlPkg::T6: begin
                addr      = cpuCtrlPkg::addrVector; // Vector low byte
                nextState = cpuCtrlPkg::T7;
            end
            cpuCtrlPkg::T7: addr = cpuCtrlPkg::addrVector;
            default: nextState = cpuCtrlPkg::T1;
        endcase
    end

    always_ff @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            state    <= cpuCtrlPkg::T1;
            classReg <= cpuCtrlPkg::classImplied;
            vecReg   <= cpuCtrlPkg::srcNone;
            intAck   <= 1'b0;
        end else begin
            if (advance) begin
                state <= nextState;
            end
            if (op.fetchDone) begin
                classReg <= cpuCtrlPkg::classOf(op.preOp);
            end
            if (fetch) begin
                vecReg <= (intReq && !intAck) ? intSrc : cpuCtrlPkg::srcNone;
            end
            // Acknowledge covers T7, released once the request is gone
            if (advance && state == cpuCtrlPkg::T6 && vecReg != cpuCtrlPkg::srcNone) begin
                intAck <= 1'b1;
            end else if (!intReq) begin
                intAck <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* controlFrontEnd.sv */
// Control front end top; single clock phi1, phi2 is the asynchronous active-high reset
`default_nettype none
`timescale 1ns/1ps

module controlFrontEnd #(
    parameter int syncStages = 2 // Interrupt pin synchronizer depth
) (
    input  wire                   phi1,
    input  wire                   phi2,
    input  wire  [7:0]            dataIn,
    input  wire                   rdy,
    input  wire                   nmiL,
    input  wire                   irqL,
    input  wire                   resL,
    input  wire                   iFlag,
    output logic                  sync,
    output logic                  rw,      // 1 is read
    output cpuCtrlPkg::addrSrc    addr,
    output cpuCtrlPkg::intSource  vecSel,
    output cpuCtrlPkg::tState     state,
    output logic [7:0]            opcode,
    output logic [7:0]            prevOpcode
);

    logic                 intReq;
    logic                 intAck;
    logic                 fetch;
    cpuCtrlPkg::intSource intSrc;

    opcodeIf opBus ();

    interruptUnit #(
        .syncStages(syncStages)
    ) interruptUnit_i (
        .phi1(phi1), .phi2(phi2),
        .nmiL(nmiL), .irqL(irqL), .resL(resL), .iFlag(iFlag),
        .intAck(intAck), .intReq(intReq), .intSrc(intSrc)
    );

    predecode predecode_i (
        .phi1(phi1), .phi2(phi2), .dataIn(dataIn), .fetch(fetch),
        .intReq(intReq), .intAck(intAck), .op(opBus.predec)
    );

    instructionRegister instructionRegister_i (
        .phi1(phi1), .phi2(phi2), .op(opBus.ir)
    );

    sequencer sequencer_i (
        .phi1(phi1), .phi2(phi2), .rdy(rdy), .intReq(intReq), .intSrc(intSrc),
        .intAck(intAck), .sync(sync), .rw(rw), .addr(addr), .vecSel(vecSel),
        .state(state), .fetch(fetch), .op(opBus.seq)
    );

    assign opcode     = opBus.opcode;
    assign prevOpcode = opBus.prevOpcode;

endmodule

`default_nettype wire

/* controlFrontEnd_properties.sv */
// Protocol checks bound into controlFrontEnd; failCount is read by the testbench for its summary
`default_nettype none
`timescale 1ns/1ps

module controlFrontEnd_properties (
    input wire                        phi1,
    input wire                        phi2,
    input wire                        sync,
    input wire                        rw,
    input wire cpuCtrlPkg::intSource  vecSel,
    input wire cpuCtrlPkg::tState     state,
    input wire                        intReq,
    input wire                        intAck,
    input wire cpuCtrlPkg::intSource  intSrc
);

    int failCount = 0;

    syncIsRead: assert property (@(posedge phi1) disable iff (phi2) sync |-> rw)
        else begin failCount++; $error("sync cycle is not a read"); end

    resetNoWrite: assert property (@(posedge phi1) disable iff (phi2)
        vecSel == cpuCtrlPkg::srcReset |-> rw)
        else begin failCount++; $error("write during reset entry"); end

    legalState: assert property (@(posedge phi1) disable iff (phi2)
        state inside {cpuCtrlPkg::T1, cpuCtrlPkg::T2, cpuCtrlPkg::T3, cpuCtrlPkg::T4,
                      cpuCtrlPkg::T5, cpuCtrlPkg::T6, cpuCtrlPkg::T7})
        else begin failCount++; $error("state holds an illegal encoding"); end

    // Four-phase link between interrupt unit and sequencer
    reqRiseAckLow: assert property (@(posedge phi1) disable iff (phi2)
        $rose(intReq) |-> !$past(intAck))
        else begin failCount++; $error("intReq rose while intAck was high"); end

    srcStable: assert property (@(posedge phi1) disable iff (phi2)
        intReq && $past(intReq) |-> intSrc == $past(intSrc))
        else begin failCount++; $error("intSrc changed during a request"); end

    reqDropOnAck: assert property (@(posedge phi1) disable iff (phi2)
        intReq && intAck |=> !intReq)
        else begin failCount++; $error("intReq not dropped after intAck"); end

    ackDropAfterReq: assert property (@(posedge phi1) disable iff (phi2)
        $fell(intAck) |-> !$past(intReq))
        else begin failCount++; $error("intAck dropped while intReq was high"); end

endmodule

bind controlFrontEnd controlFrontEnd_properties protocolChecks (
    .phi1(phi1), .phi2(phi2), .sync(sync), .rw(rw), .vecSel(vecSel), .state(state),
    .intReq(intReq), .intAck(intAck), .intSrc(intSrc)
);

`default_nettype wire

/* tbControlFrontEnd.sv */
// Testbench for controlFrontEnd with syncStages 2; a cycle model drives the output assertions
`default_nettype none
`timescale 1ns/1ps

module tbControlFrontEnd;

    localparam int budgetCycles = 100 + 40 + 600 + 250 + 250 + 20; // Per test, plus tail
    localparam int watchdogNs   = (budgetCycles * 12 / 10 + 10) * 100;

    logic phi1, phi2, rdy, nmiL, irqL, resL, iFlag, stallMode;
    logic [7:0] dataIn;
    logic sync, rw;
    cpuCtrlPkg::addrSrc   addr;
    cpuCtrlPkg::intSource vecSel;
    cpuCtrlPkg::tState    state;
    logic [7:0] opcode, prevOpcode;

    // Reference model state
    logic [2:0] pos, mLen, s1, s2, pick;
    logic [7:0] mPreOp, mOp, mPrev;
    logic mZw, prevRes, prevNmi, pendRes, pendNmi, mReq, mAck;
    logic expRw, adv, takeNow, resFall, nmiFall, served;
    cpuCtrlPkg::intSource mVec, mSrc, expVec;
    cpuCtrlPkg::addrSrc   expAddr;
    int errCount = 0, fetchCount = 0, testCount = 0, servedIrq = 0, servedNmi = 0;
    int servedRes = 0, errAtStart, seedVal;

    controlFrontEnd #(.syncStages(2)) controlFrontEnd_i (
        .phi1(phi1), .phi2(phi2), .dataIn(dataIn), .rdy(rdy), .nmiL(nmiL), .irqL(irqL),
        .resL(resL), .iFlag(iFlag), .sync(sync), .rw(rw), .addr(addr), .vecSel(vecSel),
        .state(state), .opcode(opcode), .prevOpcode(prevOpcode)
    );

    // Cycles from sync to sync, straight from the opcode table
    function automatic logic [2:0] lengthOf(input logic [7:0] b);
        case (b)
            8'h00:        return 3'd7;
            8'hA5, 8'h85: return 3'd3;
            8'hAD:        return 3'd4;
            default:      return 3'd2;
        endcase
    endfunction

    always_comb begin
        expRw   = 1'b1;
        expAddr = cpuCtrlPkg::addrPc;
        if (pos == 3'd3 && mLen == 3'd3) begin
            expAddr = cpuCtrlPkg::addrOperand;
            expRw   = !mZw;
        end else if (pos == 3'd4 && mLen == 3'd4) begin
            expAddr = cpuCtrlPkg::addrOperand;
        end else if (mLen == 3'd7 && pos >= 3'd3 && pos <= 3'd5) begin
            expAddr = cpuCtrlPkg::addrStack;
            expRw   = (mVec == cpuCtrlPkg::srcReset); // Pushes skipped on reset
        end else if (mLen == 3'd7 && pos >= 3'd6) begin
            expAddr = cpuCtrlPkg::addrVector;
        end
        expVec  = (pos == 3'd1) ? cpuCtrlPkg::srcNone : mVec;
        adv     = rdy || !expRw;
        takeNow = mReq && !mAck;
        resFall = prevRes && !s2[2];
        nmiFall = prevNmi && !s2[1];
        served  = mReq && mAck;
        if (pendRes || resFall) pick = 3'd3;
        else if (pendNmi || nmiFall) pick = 3'd2;
        else if (!s2[0] && !iFlag) pick = 3'd1; // IRQ is a masked level
        else pick = 3'd0;
    end

    always @(posedge phi1 or posedge phi2) begin
        if (phi2) begin
            pos <= 3'd1;
            mLen <= 3'd2;
            mZw <= 1'b0;
            mVec <= cpuCtrlPkg::srcNone;
            mPreOp <= 8'h00;
            mOp <= 8'h00;
            mPrev <= 8'h00;
            s1 <= 3'b111;
            s2 <= 3'b111;
            prevRes <= 1'b1;
            prevNmi <= 1'b1;
            pendRes <= 1'b0;
            pendNmi <= 1'b0;
            mReq <= 1'b0;
            mAck <= 1'b0;
            mSrc <= cpuCtrlPkg::srcNone;
        end else begin
            s1 <= {resL, nmiL, irqL};
            s2 <= s1;
            prevRes <= s2[2];
            prevNmi <= s2[1];
            pendRes <= (pendRes && !(served && mSrc == cpuCtrlPkg::srcReset)) || resFall;
            pendNmi <= (pendNmi && !(served && mSrc == cpuCtrlPkg::srcNmi)) || nmiFall;
            if (served) begin
                mReq <= 1'b0;
            end else if (!mReq && !mAck && pick != 3'd0) begin
                mReq <= 1'b1;
                mSrc <= cpuCtrlPkg::intSource'(pick[1:0]);
            end
            if (adv && pos == 3'd6 && mVec != cpuCtrlPkg::srcNone) mAck <= 1'b1;
            else if (!mReq) mAck <= 1'b0;
            if (pos == 3'd1 && rdy) begin // Fetch edge
                fetchCount <= fetchCount + 1;
                mPreOp <= takeNow ? 8'h00 : dataIn;
                mLen   <= takeNow ? 3'd7 : lengthOf(dataIn);
                mZw    <= !takeNow && dataIn == 8'h85;
                mVec   <= takeNow ? mSrc : cpuCtrlPkg::srcNone;
                if (takeNow && mSrc == cpuCtrlPkg::srcIrq) servedIrq <= servedIrq + 1;
                if (takeNow && mSrc == cpuCtrlPkg::srcNmi) servedNmi <= servedNmi + 1;
                if (takeNow && mSrc == cpuCtrlPkg::srcReset) servedRes <= servedRes + 1;
            end
            if (pos == 3'd2 && adv) begin
                mOp   <= mPreOp;
                mPrev <= mOp;
            end
            if (adv) pos <= (pos == mLen) ? 3'd1 : pos + 3'd1;
        end
    end

    stateMatch: assert property (@(posedge phi1) disable iff (phi2)
        state == cpuCtrlPkg::tState'(pos - 3'd1))
        else begin
            errCount++;
            $display("[ERROR] %0t: state differs from model", $time);
        end
    syncMatch: assert property (@(posedge phi1) disable iff (phi2) sync == (pos == 3'd1))
        else begin
            errCount++;
            $display("[ERROR] %0t: sync differs from model", $time);
        end
    rwMatch: assert property (@(posedge phi1) disable iff (phi2) rw == expRw)
        else begin
            errCount++;
            $display("[ERROR] %0t: rw differs from model", $time);
        end
    addrMatch: assert property (@(posedge phi1) disable iff (phi2) addr == expAddr)
        else begin
            errCount++;
            $display("[ERROR] %0t: addr differs from model", $time);
        end
    vecMatch: assert property (@(posedge phi1) disable iff (phi2) vecSel == expVec)
        else begin
            errCount++;
            $display("[ERROR] %0t: vecSel differs from model", $time);
        end
    opMatch: assert property (@(posedge phi1) disable iff (phi2)
        opcode == mOp && prevOpcode == mPrev)
        else begin
            errCount++;
            $display("[ERROR] %0t: opcode pair differs", $time);
        end

    function automatic int totalErrors();
        return errCount + controlFrontEnd_i.protocolChecks.failCount;
    endfunction

    // Holds the byte on dataIn until a fetch edge has taken it
    task automatic issue(input logic [7:0] b);
        int start;
        start  = fetchCount;
        dataIn = b;
        while (fetchCount == start) begin
            @(posedge phi1);
            #5;
            if (stallMode) rdy = ($urandom_range(0, 2) != 0);
        end
    endtask

    function automatic logic [7:0] fillerOp();
        logic [7:0] b;
        b = 8'($urandom());
        while (lengthOf(b) != 3'd2 || b == 8'hEA || b == 8'hA9) b = 8'($urandom());
        return b;
    endfunction

    task automatic startTest();
        errAtStart = totalErrors();
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %s finished with %0d new errors", name, totalErrors() - errAtStart);
    endtask

    initial begin
        phi1 = 1'b0;
        forever #50 phi1 = ~phi1;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired: the tests did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        seedVal = $urandom(32'h2242_cf84);
        phi2 = 1'b1;
        dataIn = 8'hEA;
        rdy = 1'b1;
        stallMode = 1'b0;
        nmiL = 1'b1;
        irqL = 1'b1;
        resL = 1'b1;
        iFlag = 1'b1;
        repeat (10) @(posedge phi1);
        #5 phi2 = 1'b0;

        startTest();
        repeat (2) begin
            issue(8'hEA);
            issue(8'hA9);
            issue(8'hA5);
            issue(8'h85);
            issue(8'hAD);
            issue(fillerOp());
        end
        endTest("lengths");

        startTest();
        issue(8'h85);
        issue(8'h00);
        issue(8'hEA);
        endTest("writes");

        startTest();
        stallMode = 1'b1;
        repeat (24) begin
            case ($urandom_range(0, 5))
                0: issue(8'h85);
                1: issue(8'h00);
                2: issue(8'hAD);
                3: issue(8'hA5);
                4: issue(8'hA9);
                default: issue(fillerOp());
            endcase
        end
        stallMode = 1'b0;
        rdy = 1'b1;
        endTest("rdyStalls");

        startTest();
        nmiL = 1'b0;
        issue(8'hEA);
        issue(8'hA9);
        nmiL = 1'b1;
        repeat (3) issue(8'hA5);
        irqL = 1'b0;
        repeat (3) issue(8'hEA); // Masked by iFlag
        iFlag = 1'b0;
        repeat (3) issue(8'hEA);
        irqL = 1'b1;
        iFlag = 1'b1;
        repeat (2) issue(8'hEA);
        endTest("interruptEntry");

        startTest();
        nmiL = 1'b0;
        irqL = 1'b0;
        iFlag = 1'b0;
        repeat (6) issue(8'hEA);
        nmiL = 1'b1;
        irqL = 1'b1;
        iFlag = 1'b1;
        issue(8'hEA);
        resL = 1'b0;
        nmiL = 1'b0; // NMI edge together with the reset edge
        issue(8'hEA);
        issue(8'hEA);
        resL = 1'b1;
        nmiL = 1'b1;
        repeat (4) issue(8'h85);
        endTest("priorityReset");

        repeat (20) @(posedge phi1);
        if (servedNmi == 0 || servedIrq == 0 || servedRes == 0) begin
            errCount++;
            $display("At least one interrupt source was never entered");
        end
        $display("Summary: %0d tests run, %0d errors", testCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
cpuCtrlPkg.sv
opcodeIf.sv
interruptUnit.sv
predecode.sv
instructionRegister.sv
sequencer.sv
controlFrontEnd.sv
controlFrontEnd_properties.sv
tbControlFrontEnd.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits non-zero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tbControlFrontEnd -o simControlFrontEnd
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simControlFrontEnd +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^NO ERRORS$" sim.log; then
    echo "Run passed"
    exit 0
fi
echo "Run failed"
exit 1
